// ==== build.f ====
+incdir+src
src/rp_pkg.sv
src/sys_bus_if.sv
src/sys_bus_decoder.sv
src/house_keeping.sv
src/adc_front.sv
src/level_gen.sv
src/prop_ctrl.sv
src/dac_back.sv
src/rp_top.sv
sim/tb_rp_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rp_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_rp_top.sv ====
`default_nettype none
`include "rp_defines.svh"

module tb_rp_top;

  localparam int CLK_PERIOD  = 10;
  localparam int BUS_XFERS   = 40;   // upper bound over all tests
  localparam int XFER_CYCLES = 4;    // strobe, ack and slack
  localparam int RAND_CYCLES = 600;  // random ADC cycles over all tests
  localparam int WD_CYCLES   = 2 * (BUS_XFERS * XFER_CYCLES + RAND_CYCLES);
  localparam int SMAX        = 2**(`RP_DAT_W-1) - 1;
  localparam int SMIN        = -(2**(`RP_DAT_W-1));
  localparam logic [`RP_DAT_W-1:0] FLIP = {1'b0, {(`RP_DAT_W-1){1'b1}}};

  logic                 adc_clk;
  logic                 rst_i;
  logic [`RP_AW-1:0]    sys_addr_i;
  logic [`RP_DW-1:0]    sys_wdata_i;
  logic                 sys_wen_i;
  logic                 sys_ren_i;
  logic [`RP_DW-1:0]    sys_rdata_o;
  logic                 sys_err_o;
  logic                 sys_ack_o;
  logic [`RP_ADC_W-1:0] adc_dat_a_i;
  logic [`RP_ADC_W-1:0] adc_dat_b_i;
  logic [`RP_DAT_W-1:0] dac_dat_a_o;
  logic [`RP_DAT_W-1:0] dac_dat_b_o;
  logic [7:0]           led_o;

  integer            seed = 17929;
  bit                adc_rand;   // random ADC words each cycle
  logic [`RP_DW-1:0] bus_rdata;  // last bus answer
  logic              bus_err;
  rp_pkg::gain_t     ga, gb;
  rp_pkg::sample_t   la, lb;

  // model state with index 0 for channel A
  int                   m_gain  [2];
  int                   m_level [2];
  int                   m_x     [2];  // converted ADC register
  int                   m_u1    [2];  // controller input one cycle back
  int                   m_u2    [2];  // two cycles back
  int                   m_g1    [2];  // gain seen with m_u1
  int                   m_g2    [2];
  bit                   m_loop;
  bit                   m_ack;        // strobe seen at the last edge
  bit                   m_err;        // that strobe hit a hole in the map
  logic [7:0]           m_led;
  logic [`RP_DAT_W-1:0] exp_code [2];
  bit                   model_ok;

  rp_top dut_i (
    .rst_i       (rst_i),
    .adc_clk     (adc_clk),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_err_o   (sys_err_o),
    .sys_ack_o   (sys_ack_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////////////////////////////////
  // reference arithmetic
  ////////////////////////////////////////////////////////////////////

  function automatic int clamp14(input longint v);
    if (v > SMAX) return SMAX;
    if (v < SMIN) return SMIN;
    return int'(v);
  endfunction

  function automatic int scale_gain(input int u, input int g);
    longint p;
    p = longint'(u) * longint'(g);
    return clamp14(p >>> `RP_GAIN_SHIFT);  // rounds toward minus infinity
  endfunction

  // two's complement to negative slope with the sign bit kept
  function automatic logic [`RP_DAT_W-1:0] to_code(input int s);
    logic [`RP_DAT_W-1:0] b;
    b = s[`RP_DAT_W-1:0];
    return b ^ FLIP;
  endfunction

  function automatic int adc_to_int(input logic [`RP_ADC_W-1:0] w);
    logic [`RP_DAT_W-1:0] c;
    c = w[`RP_ADC_W-1:2] ^ FLIP;  // reserved LSBs dropped
    return int'($signed(c));
  endfunction

  function automatic logic [`RP_ADC_W-1:0] word_of(input int s);
    return {to_code(s), 2'b11};  // junk in the reserved bits
  endfunction

  // DAC code for controller input u, gain g and level lv
  function automatic logic [`RP_DAT_W-1:0] ref_dac(input int u, input int g, input int lv);
    return to_code(clamp14(lv + scale_gain(u, g)));
  endfunction

  function automatic logic [`RP_AW-1:0] reg_addr(input rp_pkg::region_e r,
                                                 input logic [`RP_REG_W-1:0] off);
    return {9'h155, r, off};  // upper bits must be ignored
  endfunction

  ////////////////////////////////////////////////////////////////////
  // model stepping on every edge with the inputs the DUT samples
  ////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin : model_step
    int                   s;
    rp_pkg::region_e      rg;
    logic [`RP_REG_W-1:0] off;
    if (rst_i) begin
      for (int ch = 0; ch < 2; ch++) begin
        m_gain[ch]   = 0;
        m_level[ch]  = 0;
        m_x[ch]      = 0;
        m_u1[ch]     = 0;
        m_u2[ch]     = 0;
        m_g1[ch]     = 0;
        m_g2[ch]     = 0;
        exp_code[ch] = to_code(0);
      end
      m_loop   = 1'b0;
      m_ack    = 1'b0;
      m_err    = 1'b0;
      m_led    = '0;
      model_ok = 1'b1;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        s = clamp14(m_level[ch] + scale_gain(m_u2[ch], m_g2[ch]));  // DAC sum now
        exp_code[ch] = ref_dac(m_u2[ch], m_g2[ch], m_level[ch]);
        m_u2[ch] = m_u1[ch];
        m_u1[ch] = m_loop ? s : m_x[ch];  // loopback feeds the sum back
        m_g2[ch] = m_g1[ch];
        m_g1[ch] = m_gain[ch];
      end
      m_x[0] = adc_to_int(adc_dat_a_i);
      m_x[1] = adc_to_int(adc_dat_b_i);
      rg  = rp_pkg::region_e'(sys_addr_i[22:20]);
      off = sys_addr_i[`RP_REG_W-1:0];
      // bus answer one cycle after the strobe
      m_ack = sys_wen_i | sys_ren_i;
      m_err = m_ack &&
              !(rg inside {rp_pkg::REGION_HK, rp_pkg::REGION_GEN, rp_pkg::REGION_CTRL});
      if (sys_wen_i) begin
        case (rg)
          rp_pkg::REGION_HK: begin
            if (off == 'h4) m_loop = sys_wdata_i[0];
            if (off == 'h8) m_led  = sys_wdata_i[7:0];
          end
          rp_pkg::REGION_GEN: begin
            if (off == 'h0) m_level[0] = int'($signed(sys_wdata_i[`RP_DAT_W-1:0]));
            if (off == 'h4) m_level[1] = int'($signed(sys_wdata_i[`RP_DAT_W-1:0]));
          end
          rp_pkg::REGION_CTRL: begin
            if (off == 'h0) m_gain[0] = int'($signed(sys_wdata_i[`RP_GAIN_W-1:0]));
            if (off == 'h4) m_gain[1] = int'($signed(sys_wdata_i[`RP_GAIN_W-1:0]));
          end
          default: ;  // holes in the map change nothing
        endcase
      end
    end
  end

  // compare at the falling edge where outputs are settled
  always @(negedge adc_clk) begin
    if (model_ok) begin
      assert (dac_dat_a_o === exp_code[0])
        else report_error($sformatf("FAIL %0t: dac a is %h, expected %h",
                                    $time, dac_dat_a_o, exp_code[0]));
      assert (dac_dat_b_o === exp_code[1])
        else report_error($sformatf("FAIL %0t: dac b is %h, expected %h",
                                    $time, dac_dat_b_o, exp_code[1]));
      assert (led_o === m_led)
        else report_error($sformatf("FAIL %0t: led_o is %h, expected %h", $time, led_o, m_led));
      assert (sys_ack_o === m_ack)
        else report_error($sformatf("FAIL %0t: sys_ack_o is %b, expected %b",
                                    $time, sys_ack_o, m_ack));
      assert (sys_err_o === m_err)
        else report_error($sformatf("FAIL %0t: sys_err_o is %b, expected %b",
                                    $time, sys_err_o, m_err));
    end
  end

  always @(posedge adc_clk) begin
    if (adc_rand) begin
      adc_dat_a_i <= `RP_ADC_W'($random(seed));
      adc_dat_b_i <= `RP_ADC_W'($random(seed));
    end
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    report_error($sformatf("timeout, the test did not finish within %0d cycles", WD_CYCLES));
  end

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  task automatic report_error(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else report_error($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  // one strobe then a wait for ack
  task automatic bus_xfer(input bit wr, input logic [`RP_AW-1:0] addr,
                          input logic [`RP_DW-1:0] wdata);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
    @(negedge adc_clk);
    while (!sys_ack_o) begin
      if (waited == XFER_CYCLES)
        report_error($sformatf("no bus ack for address %h", addr));
      waited++;
      @(negedge adc_clk);
    end
    bus_rdata = sys_rdata_o;
    bus_err   = sys_err_o;
  endtask

  task automatic write_reg(input logic [`RP_AW-1:0] addr, input logic [`RP_DW-1:0] data);
    bus_xfer(1'b1, addr, data);
    expect_eq("write err", 32'(bus_err), 32'h0);
  endtask

  task automatic read_check(input logic [`RP_AW-1:0] addr, input logic [`RP_DW-1:0] exp);
    bus_xfer(1'b0, addr, '0);
    expect_eq("read err", 32'(bus_err), 32'h0);
    expect_eq($sformatf("rdata at %h", addr), bus_rdata, exp);
  endtask

  task automatic run_random(input int cycles);
    @(negedge adc_clk);
    adc_rand = 1'b1;
    repeat (cycles) @(negedge adc_clk);
    adc_rand = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    rst_i       = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = word_of(0);
    adc_dat_b_i = word_of(0);
    adc_rand    = 1'b0;
    repeat (2) @(posedge adc_clk);
    rst_i <= 1'b0;
    @(negedge adc_clk);

    // reset values, ID and LEDs
    expect_eq("led_o after reset", 32'(led_o), 32'h0);
    expect_eq("dac a after reset", 32'(dac_dat_a_o), 32'h1FFF);
    expect_eq("dac b after reset", 32'(dac_dat_b_o), 32'h1FFF);
    read_check(reg_addr(rp_pkg::REGION_HK, 'h0), `RP_HK_ID);
    write_reg(reg_addr(rp_pkg::REGION_HK, 'h8), 32'h0000_00A5);
    expect_eq("led_o", 32'(led_o), 32'hA5);
    read_check(reg_addr(rp_pkg::REGION_HK, 'h8), 32'hA5);
    read_check(reg_addr(rp_pkg::REGION_HK, 'hC), 32'h0);  // unknown offset

    // holes in the map answer with err
    for (int r = 3; r < `RP_REGIONS; r++) begin
      bus_xfer(1'b1, reg_addr(rp_pkg::region_e'(r), 'h0), 32'hDEAD_0000 | r);
      expect_eq("unmapped write err", 32'(bus_err), 32'h1);
      bus_xfer(1'b0, reg_addr(rp_pkg::region_e'(r), 'h4), '0);
      expect_eq("unmapped read err", 32'(bus_err), 32'h1);
      expect_eq("unmapped rdata", bus_rdata, 32'h0);
    end

    // controller path with levels still 0
    ga = rp_pkg::gain_t'($random(seed) % 6000);
    gb = rp_pkg::gain_t'($random(seed));
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h0), 32'(ga));
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h4), 32'(gb));
    read_check(reg_addr(rp_pkg::REGION_CTRL, 'h0), 32'(ga));  // sign extended
    read_check(reg_addr(rp_pkg::REGION_CTRL, 'h4), 32'(gb));
    run_random(120);
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h0), 32'(gb));
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h4), 32'($random(seed) % 6000));
    run_random(120);

    // extreme levels at unity gain clamp the sums
    @(posedge adc_clk);
    adc_dat_a_i <= word_of(6000);
    adc_dat_b_i <= word_of(-6000);
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h0), 32'd4096);
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h4), 32'd4096);
    write_reg(reg_addr(rp_pkg::REGION_GEN, 'h0), 32'(SMAX));
    write_reg(reg_addr(rp_pkg::REGION_GEN, 'h4), 32'(SMIN));
    read_check(reg_addr(rp_pkg::REGION_GEN, 'h0), 32'h0000_1FFF);
    read_check(reg_addr(rp_pkg::REGION_GEN, 'h4), 32'hFFFF_E000);
    repeat (6) @(negedge adc_clk);
    expect_eq("dac a at positive clamp", 32'(dac_dat_a_o), 32'h0000);
    expect_eq("dac b at negative clamp", 32'(dac_dat_b_o), 32'h3FFF);

    // loopback first with gain 0
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h0), 32'h0);
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h4), 32'h0);
    la = rp_pkg::sample_t'($random(seed));
    lb = rp_pkg::sample_t'($random(seed));
    write_reg(reg_addr(rp_pkg::REGION_GEN, 'h0), 32'(la));
    write_reg(reg_addr(rp_pkg::REGION_GEN, 'h4), 32'(lb));
    write_reg(reg_addr(rp_pkg::REGION_HK, 'h4), 32'h1);
    read_check(reg_addr(rp_pkg::REGION_HK, 'h4), 32'h1);
    run_random(12);
    expect_eq("loopback dac a", 32'(dac_dat_a_o), 32'(to_code(int'(la))));
    expect_eq("loopback dac b", 32'(dac_dat_b_o), 32'(to_code(int'(lb))));
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h0), 32'd2048);  // half gain feedback
    write_reg(reg_addr(rp_pkg::REGION_CTRL, 'h4), 32'd2048);
    run_random(150);
    write_reg(reg_addr(rp_pkg::REGION_HK, 'h4), 32'h0);  // back to the ADC
    run_random(150);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/rp_top.sv ====
`default_nettype none
`include "rp_defines.svh"

module rp_top (
  input  wire logic                 rst_i,
  input  wire logic                 adc_clk,
  // system bus
  input  wire logic [`RP_AW-1:0]    sys_addr_i,
  input  wire logic [`RP_DW-1:0]    sys_wdata_i,
  input  wire logic                 sys_wen_i,
  input  wire logic                 sys_ren_i,
  output logic      [`RP_DW-1:0]    sys_rdata_o,
  output logic                      sys_err_o,
  output logic                      sys_ack_o,
  // ADC
  input  wire logic [`RP_ADC_W-1:0] adc_dat_a_i,
  input  wire logic [`RP_ADC_W-1:0] adc_dat_b_i,
  // DAC
  output logic      [`RP_DAT_W-1:0] dac_dat_a_o,
  output logic      [`RP_DAT_W-1:0] dac_dat_b_o,
  // LED
  output logic      [7:0]           led_o
);

  rp_pkg::sample_t adc_a, adc_b;    // converted ADC or loopback
  rp_pkg::sample_t gen_a, gen_b;    // constant levels
  rp_pkg::sample_t ctrl_a, ctrl_b;  // controller outputs
  rp_pkg::sample_t dac_a, dac_b;    // saturated sums
  logic            digital_loop;

  sys_bus_if bus_m    ();
  sys_bus_if bus_hk   ();
  sys_bus_if bus_gen  ();
  sys_bus_if bus_ctrl ();

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  assign bus_m.addr  = sys_addr_i;
  assign bus_m.wdata = sys_wdata_i;
  assign bus_m.wen   = sys_wen_i;
  assign bus_m.ren   = sys_ren_i;
  assign sys_rdata_o = bus_m.rdata;
  assign sys_err_o   = bus_m.err;
  assign sys_ack_o   = bus_m.ack;

  sys_bus_decoder u_dec (
    .rst_i      (rst_i),
    .adc_clk    (adc_clk),
    .bus_m      (bus_m),
    .bus_hk_o   (bus_hk),    // region 0
    .bus_gen_o  (bus_gen),   // region 1
    .bus_ctrl_o (bus_ctrl)   // region 2
  );

  house_keeping u_hk (
    .rst_i          (rst_i),
    .adc_clk        (adc_clk),
    .bus            (bus_hk),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  //////////////////////////////////////////////////////////////////////
  // analog path, ADC -> controller -> DAC
  //////////////////////////////////////////////////////////////////////

  adc_front u_adc (
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .rst_i          (rst_i),
    .adc_clk        (adc_clk),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  level_gen u_gen (
    .rst_i   (rst_i),
    .adc_clk (adc_clk),
    .bus     (bus_gen),
    .gen_a_o (gen_a),
    .gen_b_o (gen_b)
  );

  prop_ctrl u_ctrl (
    .rst_i    (rst_i),
    .adc_clk  (adc_clk),
    .bus      (bus_ctrl),
    .adc_a_i  (adc_a),
    .adc_b_i  (adc_b),
    .ctrl_a_o (ctrl_a),
    .ctrl_b_o (ctrl_b)
  );

  dac_back u_dac (
    .rst_i       (rst_i),
    .adc_clk     (adc_clk),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .ctrl_a_i    (ctrl_a),
    .ctrl_b_i    (ctrl_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// ==== src/dac_back.sv ====
`default_nettype none
`include "rp_defines.svh"

module dac_back (
  input  wire logic            rst_i,
  input  wire logic            adc_clk,
  input  wire rp_pkg::sample_t gen_a_i,
  input  wire rp_pkg::sample_t gen_b_i,
  input  wire rp_pkg::sample_t ctrl_a_i,
  input  wire rp_pkg::sample_t ctrl_b_i,
  output rp_pkg::sample_t      dac_a_o,     // saturated sum, also the loopback source
  output rp_pkg::sample_t      dac_b_o,
  output logic [`RP_DAT_W-1:0] dac_dat_a_o, // negative slope code to the pins
  output logic [`RP_DAT_W-1:0] dac_dat_b_o
);

  logic signed [`RP_DAT_W:0] sum [2];  // one guard bit
  rp_pkg::sample_t           sat [2];

  assign sum[0] = gen_a_i + ctrl_a_i;
  assign sum[1] = gen_b_i + ctrl_b_i;

  // overflow when the two top bits differ
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      if (^sum[i][`RP_DAT_W -: 2])
        sat[i] = {sum[i][`RP_DAT_W], {(`RP_DAT_W-1){~sum[i][`RP_DAT_W]}}};
      else
        sat[i] = sum[i][`RP_DAT_W-1:0];
    end
  end

  assign dac_a_o = sat[0];
  assign dac_b_o = sat[1];

  // output register
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_dat_a_o <= 14'h1FFF;  // code for 0
      dac_dat_b_o <= 14'h1FFF;
    end else begin
      dac_dat_a_o <= rp_pkg::neg_slope(sat[0]);
      dac_dat_b_o <= rp_pkg::neg_slope(sat[1]);
    end
  end

endmodule

`default_nettype wire

// ==== src/prop_ctrl.sv ====
`default_nettype none
`include "rp_defines.svh"

module prop_ctrl (
  input  wire logic            rst_i,
  input  wire logic            adc_clk,
  sys_bus_if.slave             bus,
  input  wire rp_pkg::sample_t adc_a_i,
  input  wire rp_pkg::sample_t adc_b_i,
  output rp_pkg::sample_t      ctrl_a_o,
  output rp_pkg::sample_t      ctrl_b_o
);

  localparam int PW = `RP_DAT_W + `RP_GAIN_W;  // full product width
  localparam int SW = PW - `RP_GAIN_SHIFT;     // product after the shift

  rp_pkg::gain_t        gain   [2];  // index 0 is channel A
  rp_pkg::sample_t      din    [2];
  logic signed [PW-1:0] prod   [2];  // stage one
  logic signed [SW-1:0] scaled [2];
  rp_pkg::sample_t      sat    [2];
  rp_pkg::sample_t      dout   [2];  // stage two
  logic [`RP_REG_W-1:0] off;

  assign off     = bus.addr[`RP_REG_W-1:0];
  assign bus.err = 1'b0;
  assign din[0]  = adc_a_i;
  assign din[1]  = adc_b_i;

  //////////////////////////////////////////////////////////////////////
  // gain registers, 0x0 channel A and 0x4 channel B
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      gain[0]   <= '0;
      gain[1]   <= '0;
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;

      if (bus.wen) begin
        case (off)
          'h0:     gain[0] <= rp_pkg::gain_t'(bus.wdata[`RP_GAIN_W-1:0]);
          'h4:     gain[1] <= rp_pkg::gain_t'(bus.wdata[`RP_GAIN_W-1:0]);
          default: ;
        endcase
      end

      if (bus.ren) begin
        case (off)
          'h0:     bus.rdata <= {{(`RP_DW-`RP_GAIN_W){gain[0][`RP_GAIN_W-1]}}, gain[0]};
          'h4:     bus.rdata <= {{(`RP_DW-`RP_GAIN_W){gain[1][`RP_GAIN_W-1]}}, gain[1]};
          default: bus.rdata <= '0;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // multiply, shift, saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      scaled[i] = SW'(prod[i] >>> `RP_GAIN_SHIFT);  // dropped MSBs are sign copies
      // top bits must all match the sign to fit in 14 bits
      if ((&scaled[i][SW-1:`RP_DAT_W-1]) || !(|scaled[i][SW-1:`RP_DAT_W-1]))
        sat[i] = scaled[i][`RP_DAT_W-1:0];
      else
        sat[i] = {scaled[i][SW-1], {(`RP_DAT_W-1){~scaled[i][SW-1]}}};  // clamp
    end
  end

  // two samples in flight per channel
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int i = 0; i < 2; i++) begin
        prod[i] <= '0;
        dout[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        prod[i] <= din[i] * gain[i];  // signed, full width
        dout[i] <= sat[i];
      end
    end
  end

  assign ctrl_a_o = dout[0];
  assign ctrl_b_o = dout[1];

endmodule

`default_nettype wire

// ==== src/level_gen.sv ====
`default_nettype none
`include "rp_defines.svh"

module level_gen (
  input  wire logic rst_i,
  input  wire logic adc_clk,
  sys_bus_if.slave  bus,
  output rp_pkg::sample_t gen_a_o,
  output rp_pkg::sample_t gen_b_o
);

  rp_pkg::sample_t      level_a;  // offset 0x0
  rp_pkg::sample_t      level_b;  // offset 0x4
  logic [`RP_REG_W-1:0] off;

  assign off     = bus.addr[`RP_REG_W-1:0];
  assign bus.err = 1'b0;

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      level_a   <= '0;
      level_b   <= '0;
      bus.ack   <= 1'b0;
      bus.rdata <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;

      // new level is live in the ack cycle
      if (bus.wen) begin
        case (off)
          'h0:     level_a <= rp_pkg::sample_t'(bus.wdata[`RP_DAT_W-1:0]);
          'h4:     level_b <= rp_pkg::sample_t'(bus.wdata[`RP_DAT_W-1:0]);
          default: ;
        endcase
      end

      if (bus.ren) begin
        case (off)  // sign extended readback
          'h0:     bus.rdata <= {{(`RP_DW-`RP_DAT_W){level_a[`RP_DAT_W-1]}}, level_a};
          'h4:     bus.rdata <= {{(`RP_DW-`RP_DAT_W){level_b[`RP_DAT_W-1]}}, level_b};
          default: bus.rdata <= '0;
        endcase
      end
    end
  end

  // constant level stream, one value per cycle
  assign gen_a_o = level_a;
  assign gen_b_o = level_b;

endmodule

`default_nettype wire

// ==== src/adc_front.sv ====
`default_nettype none
`include "rp_defines.svh"

module adc_front (
  input  wire logic [`RP_ADC_W-1:0] adc_dat_a_i,  // raw, negative slope
  input  wire logic [`RP_ADC_W-1:0] adc_dat_b_i,
  input  wire logic                 rst_i,
  input  wire logic                 adc_clk,
  input  wire logic                 digital_loop_i,
  input  wire rp_pkg::sample_t      dac_a_i,      // combinational DAC sums
  input  wire rp_pkg::sample_t      dac_b_i,
  output rp_pkg::sample_t           adc_a_o,
  output rp_pkg::sample_t           adc_b_o
);

  logic [`RP_DAT_W-1:0] raw_a;
  logic [`RP_DAT_W-1:0] raw_b;

  // input register, two reserved LSBs dropped
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      raw_a <= 14'h1FFF;  // code for 0
      raw_b <= 14'h1FFF;
    end else begin
      raw_a <= adc_dat_a_i[`RP_ADC_W-1 -: `RP_DAT_W];
      raw_b <= adc_dat_b_i[`RP_ADC_W-1 -: `RP_DAT_W];
    end
  end

  // two's complement, or the DAC sums in loopback
  assign adc_a_o = digital_loop_i ? dac_a_i : rp_pkg::sample_t'(rp_pkg::neg_slope(raw_a));
  assign adc_b_o = digital_loop_i ? dac_b_i : rp_pkg::sample_t'(rp_pkg::neg_slope(raw_b));

endmodule

`default_nettype wire

// ==== src/house_keeping.sv ====
`default_nettype none
`include "rp_defines.svh"

module house_keeping (
  input  wire logic rst_i,
  input  wire logic adc_clk,
  sys_bus_if.slave  bus,
  output logic [7:0] led_o,
  output logic       digital_loop_o  // ADC inputs replaced by DAC sums
);

  logic [`RP_REG_W-1:0] off;

  assign off     = bus.addr[`RP_REG_W-1:0];
  assign bus.err = 1'b0;  // unknown offsets ack without err

  // register map
  //   0x0  ID word, read only
  //   0x4  bit 0 digital loop
  //   0x8  LED byte
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      led_o          <= '0;
      digital_loop_o <= 1'b0;
      bus.ack        <= 1'b0;
      bus.rdata      <= '0;
    end else begin
      bus.ack <= bus.wen | bus.ren;

      if (bus.wen) begin
        case (off)
          'h4:     digital_loop_o <= bus.wdata[0];
          'h8:     led_o          <= bus.wdata[7:0];
          default: ;  // ID is not writable
        endcase
      end

      if (bus.ren) begin
        case (off)
          'h0:     bus.rdata <= `RP_HK_ID;
          'h4:     bus.rdata <= {{(`RP_DW-1){1'b0}}, digital_loop_o};
          'h8:     bus.rdata <= {{(`RP_DW-8){1'b0}}, led_o};
          default: bus.rdata <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/sys_bus_decoder.sv ====
`default_nettype none
`include "rp_defines.svh"

module sys_bus_decoder (
  input  wire logic rst_i,
  input  wire logic adc_clk,
  sys_bus_if.slave  bus_m,       // from the bus master
  sys_bus_if.master bus_hk_o,
  sys_bus_if.master bus_gen_o,
  sys_bus_if.master bus_ctrl_o
);

  localparam int RSW = $clog2(`RP_REGIONS);  // region select bits

  rp_pkg::region_e req_region;  // region of the current strobe
  rp_pkg::region_e sel_region;  // region of the pending answer
  logic            req;
  logic            req_mapped;
  logic            umap_ack;    // local answer for holes in the map

  assign req        = bus_m.wen | bus_m.ren;
  assign req_region = rp_pkg::region_e'(bus_m.addr[`RP_REG_W +: RSW]);  // bits 31:23 ignored

  always_comb begin
    case (req_region)
      rp_pkg::REGION_HK,
      rp_pkg::REGION_GEN,
      rp_pkg::REGION_CTRL: req_mapped = 1'b1;
      default:             req_mapped = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // request fan out
  //////////////////////////////////////////////////////////////////////

  assign bus_hk_o.addr    = bus_m.addr;
  assign bus_hk_o.wdata   = bus_m.wdata;
  assign bus_hk_o.wen     = bus_m.wen & (req_region == rp_pkg::REGION_HK);
  assign bus_hk_o.ren     = bus_m.ren & (req_region == rp_pkg::REGION_HK);

  assign bus_gen_o.addr   = bus_m.addr;
  assign bus_gen_o.wdata  = bus_m.wdata;
  assign bus_gen_o.wen    = bus_m.wen & (req_region == rp_pkg::REGION_GEN);
  assign bus_gen_o.ren    = bus_m.ren & (req_region == rp_pkg::REGION_GEN);

  assign bus_ctrl_o.addr  = bus_m.addr;
  assign bus_ctrl_o.wdata = bus_m.wdata;
  assign bus_ctrl_o.wen   = bus_m.wen & (req_region == rp_pkg::REGION_CTRL);
  assign bus_ctrl_o.ren   = bus_m.ren & (req_region == rp_pkg::REGION_CTRL);

  //////////////////////////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sel_region <= rp_pkg::REGION_HK;
      umap_ack   <= 1'b0;
    end else begin
      if (req) sel_region <= req_region;  // held until the next strobe
      umap_ack <= req & ~req_mapped;
    end
  end

  // the answering slave acks exactly one cycle after its strobe
  always_comb begin
    case (sel_region)
      rp_pkg::REGION_HK: begin
        bus_m.rdata = bus_hk_o.rdata;
        bus_m.ack   = bus_hk_o.ack;
        bus_m.err   = bus_hk_o.err;
      end
      rp_pkg::REGION_GEN: begin
        bus_m.rdata = bus_gen_o.rdata;
        bus_m.ack   = bus_gen_o.ack;
        bus_m.err   = bus_gen_o.err;
      end
      rp_pkg::REGION_CTRL: begin
        bus_m.rdata = bus_ctrl_o.rdata;
        bus_m.ack   = bus_ctrl_o.ack;
        bus_m.err   = bus_ctrl_o.err;
      end
      default: begin
        bus_m.rdata = '0;        // unmapped reads return 0
        bus_m.ack   = umap_ack;
        bus_m.err   = umap_ack;  // err together with ack
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/sys_bus_if.sv ====
`default_nettype none
`include "rp_defines.svh"

// plain strobe bus, ack one cycle after wen/ren
interface sys_bus_if;

  logic [`RP_AW-1:0] addr;
  logic [`RP_DW-1:0] wdata;
  logic              wen;    // one cycle pulse
  logic              ren;    // one cycle pulse
  logic [`RP_DW-1:0] rdata;  // valid with ack on reads
  logic              err;
  logic              ack;

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, err, ack
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, err, ack
  );

endinterface

`default_nettype wire

// ==== src/rp_pkg.sv ====
`default_nettype none
`include "rp_defines.svh"

package rp_pkg;

  // bus regions, decoded from addr[22:20]
  typedef enum logic [2:0] {
    REGION_HK   = 3'd0,  // housekeeping
    REGION_GEN  = 3'd1,  // level generator
    REGION_CTRL = 3'd2   // proportional controller
  } region_e;            // 3..7 unmapped

  typedef logic signed [`RP_DAT_W-1:0]  sample_t;  // one stream sample
  typedef logic signed [`RP_GAIN_W-1:0] gain_t;

  // negative slope code <-> two's complement, same in both directions
  function automatic logic [`RP_DAT_W-1:0] neg_slope(input logic [`RP_DAT_W-1:0] d);
    return {d[`RP_DAT_W-1], ~d[`RP_DAT_W-2:0]};  // msb kept, rest inverted
  endfunction

endpackage

`default_nettype wire

// ==== src/rp_defines.svh ====
`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// stream widths
`define RP_ADC_W      16  // raw ADC word, two reserved LSBs
`define RP_DAT_W      14  // sample width, ADC and DAC

// system bus
`define RP_AW         32
`define RP_DW         32
`define RP_REG_W      20  // offset bits inside one 1 MiB region
`define RP_REGIONS    8

// proportional controller
`define RP_GAIN_W     16  // signed gain
`define RP_GAIN_SHIFT 12  // 4096 is unity

`define RP_HK_ID      32'h5250_0001  // housekeeping offset 0

`endif
